// ==== source/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// width of the instruction id tag carried with every fetch
`define INST_ID_WIDTH 4

// address of the first fetch after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== source/isa_pkg.sv ====
package isa_pkg;

	// major opcodes, bits [6:0]
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // sub, sra, srai
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	// fixed system encodings
	localparam logic [31:0] INST_ECALL = 32'h0000_0073;
	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INST_MRET = 32'h3020_0073;

	// error code returned by the instruction fetch
	typedef enum logic [1:0] {
		FETCH_OK = 2'b00,
		FETCH_PC_MISALIGN = 2'b01,
		FETCH_BUS_ERR = 2'b10,
		FETCH_TIMEOUT = 2'b11
	} fetch_err_e;

	typedef enum logic [2:0] {
		DSP_OK = 3'b000,
		DSP_ILLEGAL = 3'b001,
		DSP_PC_MISALIGN = 3'b010,
		DSP_BUS_FAIL = 3'b011,
		DSP_LD_MISALIGN = 3'b110,
		DSP_ST_MISALIGN = 3'b111
	} dsp_err_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
		ALU_SRA, ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
	} alu_mode_e;

	// same code as funct3 of loads and stores
	typedef enum logic [2:0] {
		LS_BYTE = 3'b000,
		LS_HALF = 3'b001,
		LS_WORD = 3'b010,
		LS_BYTE_U = 3'b100,
		LS_HALF_U = 3'b101
	} ls_type_e;

	typedef enum logic [1:0] {
		CSR_UPD_WRITE = 2'b00,
		CSR_UPD_SET = 2'b01,
		CSR_UPD_CLEAR = 2'b10
	} csr_upd_e;

endpackage

// ==== source/pipe_pkg.sv ====
`include "core_defines.svh"

package pipe_pkg;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
		isa_pkg::fetch_err_e err;
		logic prdt_jump; // fetch predicted a taken jump
		logic [`INST_ID_WIDTH-1:0] id;
	} fetch_res_t;

	// msb first: mret, ecall, branch, csr, load, store, mul, div, rem
	typedef struct packed {
		logic mret;
		logic ecall;
		logic branch;
		logic csr;
		logic load;
		logic store;
		logic mul;
		logic div;
		logic rem;
	} inst_type_t;

	typedef struct packed {
		inst_type_t typ;
		logic jal;
		logic jalr;
		logic rs1_used;
		logic rs2_used;
		logic rd_used;
		logic illegal;
	} inst_class_t;

	typedef struct packed {
		isa_pkg::alu_mode_e mode;
		logic [31:0] op1;
		logic [31:0] op2;
	} alu_msg_t;

	typedef struct packed {
		logic [11:0] addr;
		isa_pkg::csr_upd_e upd;
		logic [31:0] mask; // rs1 value or zero-extended uimm
	} csr_msg_t;

	typedef struct packed {
		logic [32:0] op_a;
		logic [32:0] op_b;
		logic hi_sel; // upper half of the product
	} muldiv_msg_t;

	// views of the 71 bit dispatch payload
	typedef struct packed {
		isa_pkg::ls_type_e ls_type;
		alu_msg_t alu;
	} ls_view_t;

	typedef struct packed {
		logic [24:0] pad;
		csr_msg_t csr;
	} csr_view_t;

	typedef struct packed {
		logic [3:0] pad;
		muldiv_msg_t md;
	} md_view_t;

	typedef struct packed {
		logic [38:0] pad;
		logic [31:0] inst;
	} ill_view_t;

	typedef struct packed {
		logic [1:0] pad;
		logic prdt_jump;
		alu_msg_t alu;
	} oth_view_t;

	typedef union packed {
		ls_view_t ls;
		csr_view_t csr;
		md_view_t md;
		ill_view_t ill;
		oth_view_t oth;
	} dispatch_payload_u;

	typedef struct packed {
		dispatch_payload_u payload;
		inst_type_t typ;
		logic [31:0] pc;
		logic [31:0] brc_pc_upd_store_din; // correction pc, or store data
		logic [4:0] rd_id;
		logic rd_vld;
		isa_pkg::dsp_err_e err;
		logic [`INST_ID_WIDTH-1:0] id;
	} dispatch_msg_t;

	typedef struct packed {
		logic [4:0] rs1_id;
		logic [4:0] rs2_id;
		logic rs1_vld;
		logic rs2_vld;
	} rf_rd_req_t;

	typedef struct packed {
		logic [31:0] rs1_v;
		logic [31:0] rs2_v;
	} rf_rd_res_t;

	typedef struct packed {
		logic en;
		logic [4:0] id;
		logic [31:0] data;
	} rf_wr_t;

endpackage

// ==== source/pre_decoder.sv ====
`timescale 1ns/1ps

module pre_decoder (
	input logic [31:0] inst,
	output pipe_pkg::inst_class_t cls
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb
	begin
		cls = '0;
		case (opcode)
			isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC:
				cls.rd_used = 1'b1;
			isa_pkg::OPC_JAL:
			begin
				cls.jal = 1'b1;
				cls.rd_used = 1'b1;
			end
			isa_pkg::OPC_JALR:
			begin
				cls.jalr = 1'b1;
				cls.rs1_used = 1'b1;
				cls.rd_used = 1'b1;
				cls.illegal = funct3 != 3'b000;
			end
			isa_pkg::OPC_BRANCH:
			begin
				cls.typ.branch = 1'b1;
				cls.rs1_used = 1'b1;
				cls.rs2_used = 1'b1;
				cls.illegal = funct3[2:1] == 2'b01; // 010 and 011 unused
			end
			isa_pkg::OPC_LOAD:
			begin
				cls.typ.load = 1'b1;
				cls.rs1_used = 1'b1;
				cls.rd_used = 1'b1;
				cls.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
			end
			isa_pkg::OPC_STORE:
			begin
				cls.typ.store = 1'b1;
				cls.rs1_used = 1'b1;
				cls.rs2_used = 1'b1;
				cls.illegal = funct3[2] || (funct3[1:0] == 2'b11);
			end
			isa_pkg::OPC_OP_IMM:
			begin
				cls.rs1_used = 1'b1;
				cls.rd_used = 1'b1;
				// shift immediates constrain funct7
				if (funct3 == 3'b001)
					cls.illegal = funct7 != isa_pkg::FUNCT7_BASE;
				else if (funct3 == 3'b101)
					cls.illegal = (funct7 != isa_pkg::FUNCT7_BASE) &&
						(funct7 != isa_pkg::FUNCT7_ALT);
			end
			isa_pkg::OPC_OP:
			begin
				cls.rs1_used = 1'b1;
				cls.rs2_used = 1'b1;
				cls.rd_used = 1'b1;
				if (funct7 == isa_pkg::FUNCT7_MULDIV)
				begin
					cls.typ.mul = ~funct3[2];
					cls.typ.div = funct3[2:1] == 2'b10;
					cls.typ.rem = funct3[2:1] == 2'b11;
				end
				else if (funct7 == isa_pkg::FUNCT7_ALT)
					cls.illegal = (funct3 != 3'b000) && (funct3 != 3'b101); // sub, sra only
				else
					cls.illegal = funct7 != isa_pkg::FUNCT7_BASE;
			end
			isa_pkg::OPC_MISC_MEM:
				cls.illegal = funct3 != 3'b000; // fence goes through as a nop
			isa_pkg::OPC_SYSTEM:
			begin
				if (funct3 == 3'b000)
				begin
					cls.typ.ecall = inst == isa_pkg::INST_ECALL;
					cls.typ.mret = inst == isa_pkg::INST_MRET;
					cls.illegal = (inst != isa_pkg::INST_ECALL) &&
						(inst != isa_pkg::INST_MRET) && (inst != isa_pkg::INST_EBREAK);
				end
				else
				begin
					cls.typ.csr = 1'b1;
					cls.rd_used = 1'b1;
					cls.rs1_used = ~funct3[2]; // csrr*i use the uimm field instead
					cls.illegal = funct3[1:0] == 2'b00;
				end
			end
			default:
				cls.illegal = 1'b1;
		endcase
	end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic resetn,
	input pipe_pkg::rf_rd_req_t rd_req,
	input logic rd_req_valid,
	output logic rd_req_ready,
	output pipe_pkg::rf_rd_res_t rd_res,
	output logic rd_res_valid,
	input pipe_pkg::rf_wr_t wr
);

	logic [31:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr.en && (wr.id != 5'd0))
			regs[wr.id] <= wr.data;
	end

	// unused or x0 index reads back zero
	function automatic logic [31:0] read_port(input logic [4:0] id, input logic vld);
		if (vld && (id != 5'd0))
			return regs[id];
		return '0;
	endfunction

	// combinational read, response in the request cycle
	assign rd_req_ready = 1'b1;
	assign rd_res_valid = rd_req_valid;

	always_comb
	begin
		rd_res.rs1_v = read_port(rd_req.rs1_id, rd_req.rs1_vld);
		rd_res.rs2_v = read_port(rd_req.rs2_id, rd_req.rs2_vld);
	end

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
	input pipe_pkg::fetch_res_t fetch,
	input pipe_pkg::inst_class_t cls,
	input pipe_pkg::rf_rd_res_t rf,
	output pipe_pkg::alu_msg_t alu,
	output isa_pkg::ls_type_e ls_type,
	output pipe_pkg::csr_msg_t csr,
	output pipe_pkg::muldiv_msg_t muldiv,
	output logic [31:0] brc_pc_upd,
	output logic ls_addr_aligned
);

	logic [31:0] inst;
	logic [2:0] funct3;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [31:0] pc_plus4;
	logic [31:0] rs1_plus_i; // load address and jalr target
	logic [31:0] ls_addr;
	logic [31:0] jump_tgt;
	logic op_a_signed;
	logic op_b_signed;

	function automatic isa_pkg::alu_mode_e arith_mode(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
			3'b001: return isa_pkg::ALU_SLL;
			3'b010: return isa_pkg::ALU_SLT;
			3'b011: return isa_pkg::ALU_SLTU;
			3'b100: return isa_pkg::ALU_XOR;
			3'b101: return alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
			3'b110: return isa_pkg::ALU_OR;
			default: return isa_pkg::ALU_AND;
		endcase
	endfunction

	// branch compare, taken when the alu result is 1
	function automatic isa_pkg::alu_mode_e branch_mode(input logic [2:0] f3);
		case (f3)
			3'b000: return isa_pkg::ALU_EQ;
			3'b001: return isa_pkg::ALU_NE;
			3'b100: return isa_pkg::ALU_SLT;
			3'b101: return isa_pkg::ALU_GE;
			3'b110: return isa_pkg::ALU_SLTU;
			default: return isa_pkg::ALU_GEU;
		endcase
	endfunction

	assign inst = fetch.inst;
	assign funct3 = inst[14:12];
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'd0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	assign pc_plus4 = fetch.pc + 32'd4;
	assign rs1_plus_i = rf.rs1_v + imm_i;

	always_comb
	begin
		alu.mode = isa_pkg::ALU_ADD;
		alu.op1 = '0;
		alu.op2 = '0;
		case (inst[6:0])
			isa_pkg::OPC_LUI:
				alu.op2 = imm_u;
			isa_pkg::OPC_AUIPC:
			begin
				alu.op1 = fetch.pc;
				alu.op2 = imm_u;
			end
			isa_pkg::OPC_JAL, isa_pkg::OPC_JALR:
			begin
				alu.op1 = fetch.pc; // link value
				alu.op2 = 32'd4;
			end
			isa_pkg::OPC_BRANCH:
			begin
				alu.mode = branch_mode(funct3);
				alu.op1 = rf.rs1_v;
				alu.op2 = rf.rs2_v;
			end
			isa_pkg::OPC_LOAD, isa_pkg::OPC_STORE:
			begin
				alu.op1 = rf.rs1_v;
				alu.op2 = cls.typ.store ? imm_s : imm_i;
			end
			isa_pkg::OPC_OP_IMM:
			begin
				alu.mode = arith_mode(funct3, (funct3 == 3'b101) && inst[30]);
				alu.op1 = rf.rs1_v;
				alu.op2 = imm_i;
			end
			isa_pkg::OPC_OP:
			begin
				alu.mode = arith_mode(funct3, inst[30]);
				alu.op1 = rf.rs1_v;
				alu.op2 = rf.rs2_v;
			end
			default: ;
		endcase
	end

	always_comb
	begin
		if (cls.jal)
			jump_tgt = fetch.pc + imm_j;
		else if (cls.jalr)
			jump_tgt = rs1_plus_i & ~32'd1;
		else if (cls.typ.branch)
			jump_tgt = fetch.pc + imm_b;
		else
			jump_tgt = pc_plus4;
	end

	// a predicted jump is corrected back to the fall-through pc
	assign brc_pc_upd = fetch.prdt_jump ? pc_plus4 : jump_tgt;

	assign ls_type = isa_pkg::ls_type_e'(funct3);
	assign ls_addr = cls.typ.store ? (rf.rs1_v + imm_s) : rs1_plus_i;
	assign ls_addr_aligned = (funct3[1:0] == 2'b10) ? (ls_addr[1:0] == 2'b00) :
		(funct3[1:0] == 2'b01) ? ~ls_addr[0] : 1'b1;

	assign csr.addr = inst[31:20];
	assign csr.upd = isa_pkg::csr_upd_e'(funct3[1:0] - 2'd1);
	assign csr.mask = funct3[2] ? {27'd0, inst[19:15]} : rf.rs1_v;

	// mulhu, divu, remu are unsigned; mulhsu only on operand b
	assign op_a_signed = cls.typ.mul ? (funct3[1:0] != 2'b11) : ~funct3[0];
	assign op_b_signed = cls.typ.mul ? ~funct3[1] : ~funct3[0];
	assign muldiv.op_a = {op_a_signed & rf.rs1_v[31], rf.rs1_v};
	assign muldiv.op_b = {op_b_signed & rf.rs2_v[31], rf.rs2_v};
	assign muldiv.hi_sel = cls.typ.mul && (funct3[1:0] != 2'b00);

endmodule

// ==== source/dispatch_msg_gen.sv ====
`timescale 1ns/1ps

module dispatch_msg_gen (
	input logic clk,
	input logic resetn,
	input logic sys_reset_req,
	input logic flush_req,
	input pipe_pkg::fetch_res_t fetch,
	input logic fetch_valid,
	output logic fetch_ready,
	output pipe_pkg::rf_rd_req_t rd_req,
	output logic rd_req_valid,
	input pipe_pkg::rf_rd_res_t rd_res,
	input logic rd_res_valid,
	input pipe_pkg::inst_class_t cls,
	input pipe_pkg::alu_msg_t alu,
	input isa_pkg::ls_type_e ls_type,
	input pipe_pkg::csr_msg_t csr,
	input pipe_pkg::muldiv_msg_t muldiv,
	input logic [31:0] brc_pc_upd,
	input logic ls_addr_aligned,
	output pipe_pkg::dispatch_msg_t dispatch,
	output logic dispatch_valid,
	input logic dispatch_ready
);

	logic on_flush;
	logic dsp_free; // register empty or drained this cycle
	logic fire; // fetch, read and decode complete together
	logic is_ls;
	logic is_md;
	pipe_pkg::dispatch_msg_t dsp_d;
	pipe_pkg::dispatch_msg_t dsp_q;

	assign on_flush = sys_reset_req | flush_req;
	assign dsp_free = ~dispatch_valid | dispatch_ready;

	assign rd_req_valid = fetch_valid & ~on_flush;
	assign fetch_ready = rd_res_valid & dsp_free & ~on_flush;
	assign fire = fetch_valid & fetch_ready;

	// an illegal instruction reads no registers
	assign rd_req.rs1_id = fetch.inst[19:15];
	assign rd_req.rs2_id = fetch.inst[24:20];
	assign rd_req.rs1_vld = cls.rs1_used & ~cls.illegal;
	assign rd_req.rs2_vld = cls.rs2_used & ~cls.illegal;

	assign is_ls = cls.typ.load | cls.typ.store;
	assign is_md = cls.typ.mul | cls.typ.div | cls.typ.rem;

	always_comb
	begin
		dsp_d = '0;
		// payload view by class, illegal goes to the alu as a nop
		if (cls.illegal)
			dsp_d.payload.ill.inst = fetch.inst;
		else if (is_ls)
		begin
			dsp_d.payload.ls.ls_type = ls_type;
			dsp_d.payload.ls.alu = alu;
		end
		else if (cls.typ.csr)
			dsp_d.payload.csr.csr = csr;
		else if (is_md)
			dsp_d.payload.md.md = muldiv;
		else
		begin
			dsp_d.payload.oth.prdt_jump = fetch.prdt_jump;
			dsp_d.payload.oth.alu = alu;
		end

		dsp_d.typ = cls.illegal ? '0 : cls.typ;
		dsp_d.pc = fetch.pc;
		dsp_d.brc_pc_upd_store_din = cls.typ.store ? rd_res.rs2_v : brc_pc_upd;
		dsp_d.rd_id = fetch.inst[11:7];
		dsp_d.rd_vld = cls.rd_used & ~cls.illegal;
		dsp_d.id = fetch.id;

		// illegal first, then fetch error, then misalignment
		if (cls.illegal)
			dsp_d.err = isa_pkg::DSP_ILLEGAL;
		else if (fetch.err == isa_pkg::FETCH_PC_MISALIGN)
			dsp_d.err = isa_pkg::DSP_PC_MISALIGN;
		else if (fetch.err != isa_pkg::FETCH_OK)
			dsp_d.err = isa_pkg::DSP_BUS_FAIL; // bus error or timeout
		else if (cls.typ.load && !ls_addr_aligned)
			dsp_d.err = isa_pkg::DSP_LD_MISALIGN;
		else if (cls.typ.store && !ls_addr_aligned)
			dsp_d.err = isa_pkg::DSP_ST_MISALIGN;
		else
			dsp_d.err = isa_pkg::DSP_OK;
	end

	// dispatch register, loaded only on a fetch transfer
	always_ff @(posedge clk)
	begin
		if (fire)
			dsp_q <= dsp_d;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			dispatch_valid <= 1'b0;
		else if (on_flush)
			dispatch_valid <= 1'b0;
		else if (dsp_free)
			dispatch_valid <= fire;
	end

	assign dispatch = dsp_q;

endmodule

// ==== source/decode_stage_top.sv ====
`timescale 1ns/1ps

module decode_stage_top (
	input logic clk,
	input logic resetn,
	input logic sys_reset_req,
	input logic flush_req,
	input pipe_pkg::fetch_res_t fetch,
	input logic fetch_valid,
	output logic fetch_ready,
	input pipe_pkg::rf_wr_t rf_wr,
	output pipe_pkg::dispatch_msg_t dispatch,
	output logic dispatch_valid,
	input logic dispatch_ready
);

	pipe_pkg::inst_class_t cls;
	pipe_pkg::rf_rd_req_t rd_req;
	logic rd_req_valid;
	pipe_pkg::rf_rd_res_t rd_res;
	logic rd_res_valid;
	pipe_pkg::alu_msg_t alu;
	isa_pkg::ls_type_e ls_type;
	pipe_pkg::csr_msg_t csr;
	pipe_pkg::muldiv_msg_t muldiv;
	logic [31:0] brc_pc_upd;
	logic ls_addr_aligned;

	pre_decoder u_pre_decoder (
		.inst(fetch.inst),
		.cls(cls)
	);

	// request ready is tied high inside, left open
	reg_file u_reg_file (
		.clk(clk),
		.resetn(resetn),
		.rd_req(rd_req),
		.rd_req_valid(rd_req_valid),
		.rd_req_ready(),
		.rd_res(rd_res),
		.rd_res_valid(rd_res_valid),
		.wr(rf_wr)
	);

	inst_decoder u_inst_decoder (
		.fetch(fetch),
		.cls(cls),
		.rf(rd_res),
		.alu(alu),
		.ls_type(ls_type),
		.csr(csr),
		.muldiv(muldiv),
		.brc_pc_upd(brc_pc_upd),
		.ls_addr_aligned(ls_addr_aligned)
	);

	dispatch_msg_gen u_dispatch_msg_gen (
		.clk(clk),
		.resetn(resetn),
		.sys_reset_req(sys_reset_req),
		.flush_req(flush_req),
		.fetch(fetch),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.rd_req(rd_req),
		.rd_req_valid(rd_req_valid),
		.rd_res(rd_res),
		.rd_res_valid(rd_res_valid),
		.cls(cls),
		.alu(alu),
		.ls_type(ls_type),
		.csr(csr),
		.muldiv(muldiv),
		.brc_pc_upd(brc_pc_upd),
		.ls_addr_aligned(ls_addr_aligned),
		.dispatch(dispatch),
		.dispatch_valid(dispatch_valid),
		.dispatch_ready(dispatch_ready)
	);

endmodule

// ==== sim/decode_stage_assertions.sv ====
`timescale 1ns/1ps

module decode_stage_assertions (
	input logic clk,
	input logic resetn,
	input logic sys_reset_req,
	input logic flush_req,
	input pipe_pkg::fetch_res_t fetch,
	input logic fetch_valid,
	input logic fetch_ready,
	input logic rd_req_valid,
	input pipe_pkg::rf_wr_t rf_wr,
	input pipe_pkg::dispatch_msg_t dispatch,
	input logic dispatch_valid,
	input logic dispatch_ready
);

	int errors = 0; // failed checks so far
	logic [31:0] shadow [0:31]; // register contents as written through rf_wr
	pipe_pkg::dispatch_msg_t expected;

	function automatic pipe_pkg::alu_msg_t alu_msg(input isa_pkg::alu_mode_e mode,
		input logic [31:0] op1, input logic [31:0] op2);
		pipe_pkg::alu_msg_t r;
		r.mode = mode;
		r.op1 = op1;
		r.op2 = op2;
		return r;
	endfunction

	// expected message for one fetch, a and b are the rs1 and rs2 contents
	function automatic pipe_pkg::dispatch_msg_t model_msg(input pipe_pkg::fetch_res_t f,
		input logic [31:0] a, input logic [31:0] b);
		pipe_pkg::dispatch_msg_t m;
		logic [31:0] i;
		logic [2:0] f3;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] addr;
		logic illegal;
		logic [1:0] sgn;
		logic misaligned;
		i = f.inst;
		f3 = i[14:12];
		imm_i = {{20{i[31]}}, i[31:20]};
		imm_s = {{20{i[31]}}, i[31:25], i[11:7]};
		illegal = 1'b0;
		addr = '0;
		sgn = 2'b11;
		m = '0;
		m.pc = f.pc;
		m.id = f.id;
		m.rd_id = i[11:7];
		m.brc_pc_upd_store_din = f.pc + 32'd4; // fall-through
		case (i[6:0])
			isa_pkg::OPC_OP:
			begin
				m.rd_vld = 1'b1;
				if (i[31:25] == isa_pkg::FUNCT7_MULDIV)
				begin
					m.typ.mul = ~f3[2];
					m.typ.div = f3[2:1] == 2'b10;
					m.typ.rem = f3[2:1] == 2'b11;
					case (f3)
						3'b010: sgn = 2'b10; // mulhsu
						3'b011, 3'b101, 3'b111: sgn = 2'b00;
						default: sgn = 2'b11;
					endcase
					m.payload.md.md.op_a = {sgn[1] & a[31], a};
					m.payload.md.md.op_b = {sgn[0] & b[31], b};
					m.payload.md.md.hi_sel = ~f3[2] && (f3[1:0] != 2'b00);
				end
				else
				begin
					m.payload.oth.prdt_jump = f.prdt_jump;
					m.payload.oth.alu = alu_msg(i[30] ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD, a, b);
				end
			end
			isa_pkg::OPC_OP_IMM:
			begin
				m.rd_vld = 1'b1;
				m.payload.oth.prdt_jump = f.prdt_jump;
				m.payload.oth.alu = alu_msg(isa_pkg::ALU_ADD, a, imm_i);
			end
			isa_pkg::OPC_LOAD:
			begin
				m.typ.load = 1'b1;
				m.rd_vld = 1'b1;
				addr = a + imm_i;
				m.payload.ls.ls_type = isa_pkg::ls_type_e'(f3);
				m.payload.ls.alu = alu_msg(isa_pkg::ALU_ADD, a, imm_i);
			end
			isa_pkg::OPC_STORE:
			begin
				m.typ.store = 1'b1;
				addr = a + imm_s;
				m.brc_pc_upd_store_din = b; // store data
				m.payload.ls.ls_type = isa_pkg::ls_type_e'(f3);
				m.payload.ls.alu = alu_msg(isa_pkg::ALU_ADD, a, imm_s);
			end
			isa_pkg::OPC_BRANCH:
			begin
				m.typ.branch = 1'b1;
				m.payload.oth.prdt_jump = f.prdt_jump;
				m.payload.oth.alu = alu_msg(isa_pkg::ALU_EQ, a, b); // beq only
				if (!f.prdt_jump)
					m.brc_pc_upd_store_din = f.pc +
						{{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
			end
			isa_pkg::OPC_JAL:
			begin
				m.rd_vld = 1'b1;
				m.payload.oth.prdt_jump = f.prdt_jump;
				m.payload.oth.alu = alu_msg(isa_pkg::ALU_ADD, f.pc, 32'd4);
				if (!f.prdt_jump)
					m.brc_pc_upd_store_din = f.pc +
						{{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
			end
			isa_pkg::OPC_SYSTEM:
			begin
				// csr forms only
				m.typ.csr = 1'b1;
				m.rd_vld = 1'b1;
				m.payload.csr.csr.addr = i[31:20];
				case (f3[1:0])
					2'b01: m.payload.csr.csr.upd = isa_pkg::CSR_UPD_WRITE;
					2'b10: m.payload.csr.csr.upd = isa_pkg::CSR_UPD_SET;
					default: m.payload.csr.csr.upd = isa_pkg::CSR_UPD_CLEAR;
				endcase
				m.payload.csr.csr.mask = f3[2] ? {27'd0, i[19:15]} : a;
			end
			default:
			begin
				illegal = 1'b1;
				m.payload.ill.inst = i;
			end
		endcase

		misaligned = ((f3[1:0] == 2'b10) && (addr[1:0] != 2'b00)) ||
			((f3[1:0] == 2'b01) && addr[0]);
		if (illegal)
			m.err = isa_pkg::DSP_ILLEGAL;
		else if (f.err == isa_pkg::FETCH_PC_MISALIGN)
			m.err = isa_pkg::DSP_PC_MISALIGN;
		else if (f.err != isa_pkg::FETCH_OK)
			m.err = isa_pkg::DSP_BUS_FAIL;
		else if ((m.typ.load || m.typ.store) && misaligned)
			m.err = m.typ.store ? isa_pkg::DSP_ST_MISALIGN : isa_pkg::DSP_LD_MISALIGN;
		return m;
	endfunction

	// model sees register contents from before a write at the same edge
	always @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int k = 0; k < 32; k++)
				shadow[k] <= '0;
			expected <= '0;
		end
		else
		begin
			if (fetch_valid && fetch_ready)
				expected <= model_msg(fetch, shadow[fetch.inst[19:15]],
					shadow[fetch.inst[24:20]]);
			if (rf_wr.en && (rf_wr.id != 5'd0))
				shadow[rf_wr.id] <= rf_wr.data;
		end
	end

	a_msg: assert property (@(posedge clk) disable iff (!resetn)
		dispatch_valid |-> dispatch == expected)
	else
	begin
		$error("Error at %0t: dispatch message id %0d differs from the model", $time,
			dispatch.id);
		errors++;
	end

	a_accept: assert property (@(posedge clk) disable iff (!resetn)
		fetch_valid && fetch_ready |=> dispatch_valid)
	else
	begin
		$error("Error at %0t: accepted fetch did not reach dispatch", $time);
		errors++;
	end

	a_hold: assert property (@(posedge clk) disable iff (!resetn)
		dispatch_valid && !dispatch_ready && !flush_req && !sys_reset_req
		|=> dispatch_valid && $stable(dispatch))
	else
	begin
		$error("Error at %0t: dispatch changed while stalled", $time);
		errors++;
	end

	a_block: assert property (@(posedge clk) disable iff (!resetn)
		dispatch_valid && !dispatch_ready |-> !fetch_ready)
	else
	begin
		$error("Error at %0t: fetch accepted while dispatch stalled", $time);
		errors++;
	end

	a_flush: assert property (@(posedge clk) disable iff (!resetn)
		flush_req || sys_reset_req |-> (!fetch_ready && !rd_req_valid) ##1 !dispatch_valid)
	else
	begin
		$error("Error at %0t: flush did not block fetch or clear dispatch", $time);
		errors++;
	end

	a_reset: assert property (@(posedge clk)
		!resetn |-> !dispatch_valid && !fetch_ready && !rd_req_valid)
	else
	begin
		$error("Error at %0t: handshake active during reset", $time);
		errors++;
	end

endmodule

bind decode_stage_top decode_stage_assertions u_checker (
	.clk(clk),
	.resetn(resetn),
	.sys_reset_req(sys_reset_req),
	.flush_req(flush_req),
	.fetch(fetch),
	.fetch_valid(fetch_valid),
	.fetch_ready(fetch_ready),
	.rd_req_valid(rd_req_valid),
	.rf_wr(rf_wr),
	.dispatch(dispatch),
	.dispatch_valid(dispatch_valid),
	.dispatch_ready(dispatch_ready)
);

// ==== sim/tb_decode_stage.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_decode_stage;

	localparam int FLUSH_AT = 10; // program index fetched under flush_req
	localparam int SYS_RESET_AT = 19; // program index fetched under sys_reset_req

	logic clk;
	logic resetn;
	logic sys_reset_req;
	logic flush_req;
	pipe_pkg::fetch_res_t fetch;
	logic fetch_valid;
	logic fetch_ready;
	pipe_pkg::rf_wr_t rf_wr;
	pipe_pkg::dispatch_msg_t dispatch;
	logic dispatch_valid;
	logic dispatch_ready;
	logic hold_ready; // keeps dispatch stalled over a flush cycle

	integer seed = 32'hefc8_56a7;
	int cycles = 0;
	pipe_pkg::fetch_res_t prog [$]; // in fetch order

	decode_stage_top DUT (
		.clk(clk),
		.resetn(resetn),
		.sys_reset_req(sys_reset_req),
		.flush_req(flush_req),
		.fetch(fetch),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.rf_wr(rf_wr),
		.dispatch(dispatch),
		.dispatch_valid(dispatch_valid),
		.dispatch_ready(dispatch_ready)
	);

	always #50 clk = ~clk;

	// random back-pressure, ready about three cycles in four
	always @(posedge clk)
		dispatch_ready <= #1 (($random(seed) & 3) != 0) && !hold_ready;

	function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], isa_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isa_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isa_pkg::OPC_JAL};
	endfunction

	task automatic add_inst(input logic [31:0] inst,
		input isa_pkg::fetch_err_e err = isa_pkg::FETCH_OK, input logic prdt = 1'b0);
		pipe_pkg::fetch_res_t e;
		e.pc = `RESET_PC + 32'(4 * prog.size());
		e.inst = inst;
		e.err = err;
		e.prdt_jump = prdt;
		e.id = `INST_ID_WIDTH'(prog.size());
		prog.push_back(e);
	endtask

	task automatic build_program();
		add_inst(encode_r(isa_pkg::FUNCT7_BASE, 5'd2, 5'd1, 3'b000, 5'd3)); // add x3, x1, x2
		add_inst(encode_i(12'hffb, 5'd2, 3'b000, 5'd4, isa_pkg::OPC_OP_IMM)); // addi -5
		add_inst(encode_r(isa_pkg::FUNCT7_ALT, 5'd6, 5'd3, 3'b000, 5'd5)); // sub
		add_inst(encode_r(isa_pkg::FUNCT7_BASE, 5'd20, 5'd0, 3'b000, 5'd15)); // x0 and unwritten x20
		add_inst(encode_i(12'd0, 5'd1, 3'b010, 5'd6, isa_pkg::OPC_LOAD)); // lw 0(x1)
		add_inst(encode_i(12'd2, 5'd1, 3'b010, 5'd7, isa_pkg::OPC_LOAD)); // lw 2(x1) misaligned
		add_inst(encode_i(12'd2, 5'd1, 3'b001, 5'd8, isa_pkg::OPC_LOAD)); // lh 2(x1)
		add_inst(encode_s(12'd4, 5'd2, 5'd1, 3'b010)); // sw x2, 4(x1)
		add_inst(encode_s(12'd1, 5'd2, 5'd1, 3'b010)); // sw misaligned
		add_inst(encode_s(12'd3, 5'd3, 5'd1, 3'b001)); // sh misaligned
		add_inst(32'h0000_0000);
		add_inst(32'hffff_ffff);
		add_inst(encode_r(isa_pkg::FUNCT7_BASE, 5'd2, 5'd1, 3'b000, 5'd3),
			isa_pkg::FETCH_PC_MISALIGN);
		add_inst(encode_i(12'hffb, 5'd2, 3'b000, 5'd4, isa_pkg::OPC_OP_IMM),
			isa_pkg::FETCH_BUS_ERR);
		add_inst(encode_r(isa_pkg::FUNCT7_BASE, 5'd2, 5'd1, 3'b000, 5'd3),
			isa_pkg::FETCH_TIMEOUT);
		add_inst(32'h0000_0000, isa_pkg::FETCH_BUS_ERR); // illegal wins over fetch error
		add_inst(encode_i(12'd2, 5'd1, 3'b010, 5'd7, isa_pkg::OPC_LOAD),
			isa_pkg::FETCH_PC_MISALIGN);
		add_inst(encode_b(13'd16, 5'd1, 5'd1, 3'b000)); // beq, not predicted
		add_inst(encode_b(13'h1ff8, 5'd3, 5'd2, 3'b000), isa_pkg::FETCH_OK, 1'b1);
		add_inst(encode_j(21'h000800, 5'd1)); // jal x1, +2048
		add_inst(encode_j(21'h1ffffc, 5'd0), isa_pkg::FETCH_OK, 1'b1);
		add_inst(encode_i(12'h300, 5'd4, 3'b001, 5'd9, isa_pkg::OPC_SYSTEM)); // csrrw
		add_inst(encode_i(12'h341, 5'd5, 3'b111, 5'd10, isa_pkg::OPC_SYSTEM)); // csrrci
		add_inst(encode_r(isa_pkg::FUNCT7_MULDIV, 5'd3, 5'd2, 3'b000, 5'd11)); // mul
		add_inst(encode_r(isa_pkg::FUNCT7_MULDIV, 5'd5, 5'd4, 3'b011, 5'd12)); // mulhu
		add_inst(encode_r(isa_pkg::FUNCT7_MULDIV, 5'd2, 5'd5, 3'b010, 5'd11)); // mulhsu
		add_inst(encode_r(isa_pkg::FUNCT7_MULDIV, 5'd7, 5'd6, 3'b100, 5'd13)); // div
		add_inst(encode_r(isa_pkg::FUNCT7_MULDIV, 5'd9, 5'd8, 3'b111, 5'd14)); // remu
	endtask

	task automatic write_reg(input logic [4:0] id, input logic [31:0] data);
		rf_wr.en = 1'b1;
		rf_wr.id = id;
		rf_wr.data = data;
		@(posedge clk);
		#1;
		rf_wr.en = 1'b0;
	endtask

	// limit grows with the program length
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= 4 * prog.size() + 50)
		begin
			$display("Some tests failed");
			$fatal(1, "run did not finish within %0d cycles", cycles);
		end
	end

	always @(negedge clk)
	begin
		if (DUT.u_checker.errors != 0)
		begin
			$display("Some tests failed");
			$fatal(1, "a checker assertion failed");
		end
	end

	initial
	begin
		logic taken;
		clk = 1'b0;
		resetn = 1'b0;
		sys_reset_req = 1'b0;
		flush_req = 1'b0;
		fetch = '0;
		fetch_valid = 1'b0;
		rf_wr = '0;
		dispatch_ready = 1'b0;
		hold_ready = 1'b0;
		build_program();
		repeat (3) @(posedge clk);
		#1;
		resetn = 1'b1;

		// x1 stays word aligned, it is the base of the load/store tests
		for (int k = 1; k <= 12; k++)
			write_reg(5'(k), (k == 1) ? ($random(seed) & 32'hffff_fffc) : $random(seed));

		for (int n = 0; n < prog.size(); n++)
		begin
			fetch = prog[n];
			fetch_valid = 1'b1;
			flush_req = n == FLUSH_AT;
			sys_reset_req = n == SYS_RESET_AT;
			rf_wr.en = n == 2; // x3 written while sub reads it
			rf_wr.id = 5'd3;
			rf_wr.data = $random(seed);
			taken = 1'b0;
			while (!taken)
			begin
				@(negedge clk);
				taken = fetch_ready;
				// the flush then meets a stalled, still valid dispatch
				hold_ready = taken && ((n + 1 == FLUSH_AT) || (n + 1 == SYS_RESET_AT));
				@(posedge clk);
				#1;
				flush_req = 1'b0;
				sys_reset_req = 1'b0;
				rf_wr.en = 1'b0;
			end
		end
		fetch_valid = 1'b0;
		fetch = '0;

		repeat (4) @(posedge clk);
		@(negedge clk);
		if (DUT.u_checker.errors == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			$display("Some tests failed");
			$fatal(1, "checker reported failures at the end of the run");
		end
	end

endmodule

// ==== vlog.f ====
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/pre_decoder.sv
source/reg_file.sv
source/inst_decoder.sv
source/dispatch_msg_gen.sv
source/decode_stage_top.sv
sim/decode_stage_assertions.sv
sim/tb_decode_stage.sv
